//--- bench/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

`include "rv_decode_consts.svh"

// sign-extend the low bits of v to 32 bits
function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    return $signed(v << (32 - bits)) >>> (32 - bits);
endfunction

function automatic alu_op_e model_alu_op(input logic [2:0] f3, input logic alt,
                                         input logic reg_reg);
    case (f3)
        3'b000:  return (reg_reg && alt) ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic branch_cond_e model_branch(input logic [2:0] f3);
    if (f3 == 3'b000) return BR_EQ;
    if (f3 == 3'b001) return BR_NE;
    // blt and bltu share lt, bge and bgeu share ge
    if (f3[2] && !f3[0]) return BR_LT;
    if (f3[2] && f3[0]) return BR_GE;
    return BR_NONE;
endfunction

function automatic decoded_uop_t expected_uop(input fetch_pkt_t pkt);
    decoded_uop_t u;
    logic [31:0]  ins;
    logic [2:0]   f3;
    ins = pkt.instr;
    f3 = ins[14:12];
    u = '0;
    u.pc = pkt.cur_pc;
    u.next_pc = pkt.next_pc;
    case (ins[6:0])
        `RV_OPC_LOAD, `RV_OPC_STORE: begin
            u.uop_class = UOP_LSU;
            u.mem_load = (ins[6:0] == `RV_OPC_LOAD);
            u.mem_size = f3[1:0];
            u.mem_unsigned = f3[2];
            u.rs1_idx = ins[19:15];
            if (u.mem_load) begin
                u.rd_idx = ins[11:7];
                u.imm = sext({20'b0, ins[31:20]}, 12);
            end else begin
                u.rs2_idx = ins[24:20];
                u.imm = sext({20'b0, ins[31:25], ins[11:7]}, 12);
            end
        end
        `RV_OPC_OP_IMM, `RV_OPC_OP: begin
            u.uop_class = UOP_ALU;
            u.alu_op = model_alu_op(f3, ins[30], ins[6:0] == `RV_OPC_OP);
            u.rs1_idx = ins[19:15];
            u.rd_idx = ins[11:7];
            if (ins[6:0] == `RV_OPC_OP) begin
                u.rs2_idx = ins[24:20];
            end else begin
                u.src2_is_imm = 1'b1;
                u.imm = sext({20'b0, ins[31:20]}, 12);
            end
        end
        `RV_OPC_LUI, `RV_OPC_AUIPC: begin
            u.uop_class = UOP_LDPC;
            u.need_pc = (ins[6:0] == `RV_OPC_AUIPC);
            u.src2_is_imm = 1'b1;
            u.rd_idx = ins[11:7];
            u.imm = {ins[31:12], 12'h000};
        end
        `RV_OPC_BRANCH: begin
            u.uop_class = UOP_JUMP;
            u.branch_cond = model_branch(f3);
            u.cmp_unsigned = f3[1];
            u.rs1_idx = ins[19:15];
            u.rs2_idx = ins[24:20];
            u.imm = sext({19'b0, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
        end
        `RV_OPC_JAL: begin
            u.uop_class = UOP_JUMP;
            u.branch_cond = BR_JAL;
            u.src2_is_imm = 1'b1;
            u.rd_idx = ins[11:7];
            u.imm = sext({11'b0, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
        end
        `RV_OPC_JALR: begin
            u.uop_class = UOP_JUMP;
            u.branch_cond = BR_JALR;
            u.src2_is_imm = 1'b1;
            u.rs1_idx = ins[19:15];
            u.rd_idx = ins[11:7];
            u.imm = sext({20'b0, ins[31:20]}, 12);
        end
        default: begin
            u.uop_class = UOP_NONE;
        end
    endcase
    return u;
endfunction

`endif

//--- bench/tb_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module tb_decode_stage
    import rv_decode_pkg::*;
();

    localparam int NUM_TXN     = 1000;
    localparam int WATCHDOG_NS = 20 * NUM_TXN * 10;

    logic         clk;
    logic         rst = 1'b1;
    logic         in_valid = 1'b0;
    fetch_pkt_t   in_pkt = '0;
    logic         in_ready;
    logic         out_valid;
    decoded_uop_t out_uop;
    logic         out_ready = 1'b0;

    integer       seed = 69;
    int           cycle_count = 0;
    int           in_count = 0;
    int           out_count = 0;
    logic         stalled_prev = 1'b0;
    decoded_uop_t held_uop;
    decoded_uop_t exp_uop;
    decoded_uop_t exp_q[$];
    logic         done = 1'b0;

    `include "decode_ref_model.svh"

    decode_stage i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_uop   (out_uop),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    task automatic compare_uop(input decoded_uop_t e, input decoded_uop_t a, input string tag);
        check_value({tag, " uop_class"}, 32'(e.uop_class), 32'(a.uop_class));
        check_value({tag, " alu_op"}, 32'(e.alu_op), 32'(a.alu_op));
        check_value({tag, " branch_cond"}, 32'(e.branch_cond), 32'(a.branch_cond));
        check_value({tag, " cmp_unsigned"}, 32'(e.cmp_unsigned), 32'(a.cmp_unsigned));
        check_value({tag, " mem_load"}, 32'(e.mem_load), 32'(a.mem_load));
        check_value({tag, " mem_size"}, 32'(e.mem_size), 32'(a.mem_size));
        check_value({tag, " mem_unsigned"}, 32'(e.mem_unsigned), 32'(a.mem_unsigned));
        check_value({tag, " need_pc"}, 32'(e.need_pc), 32'(a.need_pc));
        check_value({tag, " src2_is_imm"}, 32'(e.src2_is_imm), 32'(a.src2_is_imm));
        check_value({tag, " rs1_idx"}, 32'(e.rs1_idx), 32'(a.rs1_idx));
        check_value({tag, " rs2_idx"}, 32'(e.rs2_idx), 32'(a.rs2_idx));
        check_value({tag, " rd_idx"}, 32'(e.rd_idx), 32'(a.rd_idx));
        check_value({tag, " imm"}, e.imm, a.imm);
        check_value({tag, " pc"}, e.pc, a.pc);
        check_value({tag, " next_pc"}, e.next_pc, a.next_pc);
    endtask

    function automatic logic random_bit_70();
        return ($unsigned($random(seed)) % 10) < 7;
    endfunction

    // nine legal opcodes, index 9 is SYSTEM which the stage does not decode
    function automatic logic [6:0] opcode_for(input int unsigned sel);
        case (sel)
            0:       return `RV_OPC_LOAD;
            1:       return `RV_OPC_STORE;
            2:       return `RV_OPC_OP_IMM;
            3:       return `RV_OPC_OP;
            4:       return `RV_OPC_LUI;
            5:       return `RV_OPC_AUIPC;
            6:       return `RV_OPC_BRANCH;
            7:       return `RV_OPC_JAL;
            8:       return `RV_OPC_JALR;
            default: return 7'b1110011;
        endcase
    endfunction

    function automatic fetch_pkt_t random_pkt();
        fetch_pkt_t  p;
        int unsigned sel;
        sel = $unsigned($random(seed)) % 10;
        p.instr = $random(seed);
        p.instr[6:0] = opcode_for(sel);
        p.cur_pc = $random(seed);
        p.next_pc = p.cur_pc + 32'd4;
        return p;
    endfunction

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == 2) begin
            rst <= 1'b0;
        end else if (!rst) begin
            // sampled values are the ones present before this edge
            if (in_count == 0) begin
                check_value("idle after reset out_valid", 32'd0, 32'(out_valid));
            end
            if (stalled_prev) begin
                check_value("stall out_valid", 32'd1, 32'(out_valid));
                compare_uop(held_uop, out_uop, "stall hold");
            end
            if (out_valid && !out_ready) begin
                check_value("backpressure in_ready", 32'd0, 32'(in_ready));
            end else begin
                check_value("free slot in_ready", 32'd1, 32'(in_ready));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("output transfer seen with no instruction accepted");
                end else begin
                    exp_uop = exp_q.pop_front();
                    compare_uop(exp_uop, out_uop, $sformatf("txn %0d", out_count));
                    out_count = out_count + 1;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_uop(in_pkt));
                in_count = in_count + 1;
            end
            stalled_prev = out_valid && !out_ready;
            held_uop = out_uop;

            // a pending request holds until it is taken
            if (!(in_valid && !in_ready)) begin
                if (in_count < NUM_TXN && random_bit_70()) begin
                    in_valid <= 1'b1;
                    in_pkt <= random_pkt();
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= random_bit_70();
            if (out_count == NUM_TXN) begin
                done = 1'b1;
            end
        end
    end

    initial begin
        while (!done) begin
            @(posedge clk);
        end
        // the last output transfer empties the stage
        @(posedge clk);
        if (out_valid) begin
            fail_run("output still valid after the last instruction came out");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all instructions came out");
    end

endmodule

//--- hdl/decode_pipe_reg.sv
`timescale 1ns/1ps

module decode_pipe_reg
    import rv_decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  decoded_uop_t in_uop,
    output logic         in_ready,
    output logic         out_valid,
    output decoded_uop_t out_uop,
    input  logic         out_ready
);

    logic         occupied;
    decoded_uop_t uop_q;
    logic         load;

    // free slot, or the held item leaves this cycle
    assign in_ready = !occupied || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
        end else if (in_ready) begin
            occupied <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            uop_q <= in_uop;
        end
    end

    assign out_valid = occupied;
    assign out_uop   = uop_q;

    // stalled output must not change under the consumer
    a_stall_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_uop))
    ) else $error("decode output changed while stalled");

    // an empty stage always accepts
    a_empty_accepts: assert property (
        @(posedge clk) disable iff (rst)
        (!out_valid && in_valid) |=> out_valid
    ) else $error("decode stage empty but did not accept");

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  fetch_pkt_t   in_pkt,
    output logic         in_ready,
    output logic         out_valid,
    output decoded_uop_t out_uop,
    input  logic         out_ready
);

    decoded_uop_t dec_uop;

    // decode is combinational, the register adds the single cycle
    uop_decoder i_decoder (
        .pkt (in_pkt),
        .uop (dec_uop)
    );

    decode_pipe_reg i_pipe_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_uop    (dec_uop),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_uop   (out_uop),
        .out_ready (out_ready)
    );

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  logic [`RV_XLEN-1:0] instr,
    input  imm_fmt_e            fmt,
    output logic [`RV_XLEN-1:0] imm
);

    logic sign;

    // every format takes its sign from the top instruction bit
    assign sign = instr[`RV_XLEN-1];

    always_comb begin
        case (fmt)
            IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // offset in half-words, bit 0 always zero
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- hdl/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// datapath and register file
`define RV_XLEN           32
`define RV_REG_IDX_W      5

// instruction field positions
`define RV_OPCODE_LO      0
`define RV_OPCODE_HI      6
`define RV_OPCODE_W       7
`define RV_RD_LO          7
`define RV_FUNCT3_LO      12
`define RV_FUNCT3_W       3
`define RV_RS1_LO         15
`define RV_RS2_LO         20

// selects sub and sra
`define RV_FUNCT7_ALT_BIT 30

// major opcodes
`define RV_OPC_LOAD       7'b0000011
`define RV_OPC_STORE      7'b0100011
`define RV_OPC_OP_IMM     7'b0010011
`define RV_OPC_OP         7'b0110011
`define RV_OPC_LUI        7'b0110111
`define RV_OPC_AUIPC      7'b0010111
`define RV_OPC_BRANCH     7'b1100011
`define RV_OPC_JAL        7'b1101111
`define RV_OPC_JALR       7'b1100111

`endif

//--- hdl/rv_decode_pkg.sv
`include "rv_decode_consts.svh"

package rv_decode_pkg;

    // execution unit that takes the micro-op
    typedef enum logic [2:0] {
        UOP_NONE = 3'd0,
        UOP_LSU  = 3'd1,
        UOP_ALU  = 3'd2,
        UOP_JUMP = 3'd3,
        UOP_LDPC = 3'd4
    } uop_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_AND  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    // lt and ge cover both signed and unsigned compares
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_JAL  = 3'd5,
        BR_JALR = 3'd6
    } branch_cond_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_fmt_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] cur_pc;
        logic [`RV_XLEN-1:0] next_pc;
    } fetch_pkt_t;

    typedef struct packed {
        uop_class_e               uop_class;
        alu_op_e                  alu_op;
        branch_cond_e             branch_cond;
        logic                     cmp_unsigned;
        logic                     mem_load;
        logic [1:0]               mem_size;
        logic                     mem_unsigned;
        logic                     need_pc;
        logic                     src2_is_imm;
        logic [`RV_REG_IDX_W-1:0] rs1_idx;
        logic [`RV_REG_IDX_W-1:0] rs2_idx;
        logic [`RV_REG_IDX_W-1:0] rd_idx;
        logic [`RV_XLEN-1:0]      imm;
        logic [`RV_XLEN-1:0]      pc;
        logic [`RV_XLEN-1:0]      next_pc;
    } decoded_uop_t;

endpackage

//--- hdl/uop_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module uop_decoder
    import rv_decode_pkg::*;
(
    input  fetch_pkt_t   pkt,
    output decoded_uop_t uop
);

    logic [`RV_OPCODE_W-1:0]  opcode;
    logic [`RV_FUNCT3_W-1:0]  funct3;
    logic                     alt;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rd;
    imm_fmt_e                 imm_fmt;
    logic                     has_imm;
    logic [`RV_XLEN-1:0]      imm;

    assign opcode = pkt.instr[`RV_OPCODE_HI:`RV_OPCODE_LO];
    assign funct3 = pkt.instr[`RV_FUNCT3_LO +: `RV_FUNCT3_W];
    assign alt    = pkt.instr[`RV_FUNCT7_ALT_BIT];
    assign rs1    = pkt.instr[`RV_RS1_LO +: `RV_REG_IDX_W];
    assign rs2    = pkt.instr[`RV_RS2_LO +: `RV_REG_IDX_W];
    assign rd     = pkt.instr[`RV_RD_LO +: `RV_REG_IDX_W];

    // sub only exists for register-register ops
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic f7_alt,
                                           input logic allow_sub);
        case (f3)
            3'b000:  return (f7_alt && allow_sub) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic branch_cond_e decode_branch(input logic [2:0] f3);
        case (f3)
            3'b000:         return BR_EQ;
            3'b001:         return BR_NE;
            3'b100, 3'b110: return BR_LT;
            3'b101, 3'b111: return BR_GE;
            default:        return BR_NONE;
        endcase
    endfunction

    // immediate format per opcode
    always_comb begin
        imm_fmt = IMM_I;
        has_imm = 1'b1;
        case (opcode)
            `RV_OPC_LOAD, `RV_OPC_OP_IMM, `RV_OPC_JALR: imm_fmt = IMM_I;
            `RV_OPC_STORE:                              imm_fmt = IMM_S;
            `RV_OPC_BRANCH:                             imm_fmt = IMM_B;
            `RV_OPC_LUI, `RV_OPC_AUIPC:                 imm_fmt = IMM_U;
            `RV_OPC_JAL:                                imm_fmt = IMM_J;
            default:                                    has_imm = 1'b0;
        endcase
    end

    imm_gen i_imm_gen (
        .instr (pkt.instr),
        .fmt   (imm_fmt),
        .imm   (imm)
    );

    always_comb begin
        uop         = '0;
        uop.pc      = pkt.cur_pc;
        uop.next_pc = pkt.next_pc;
        uop.imm     = has_imm ? imm : '0;
        case (opcode)
            `RV_OPC_LOAD, `RV_OPC_STORE: begin
                uop.uop_class    = UOP_LSU;
                uop.mem_load     = (opcode == `RV_OPC_LOAD);
                uop.mem_size     = funct3[1:0];
                uop.mem_unsigned = funct3[2];
                uop.rs1_idx      = rs1;
                // stores carry data in rs2, loads write rd
                if (opcode == `RV_OPC_STORE) begin
                    uop.rs2_idx = rs2;
                end else begin
                    uop.rd_idx = rd;
                end
            end
            `RV_OPC_OP_IMM: begin
                uop.uop_class   = UOP_ALU;
                uop.alu_op      = decode_alu(funct3, alt, 1'b0);
                uop.src2_is_imm = 1'b1;
                uop.rs1_idx     = rs1;
                uop.rd_idx      = rd;
            end
            `RV_OPC_OP: begin
                uop.uop_class = UOP_ALU;
                uop.alu_op    = decode_alu(funct3, alt, 1'b1);
                uop.rs1_idx   = rs1;
                uop.rs2_idx   = rs2;
                uop.rd_idx    = rd;
            end
            `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                uop.uop_class   = UOP_LDPC;
                uop.need_pc     = (opcode == `RV_OPC_AUIPC);
                uop.src2_is_imm = 1'b1;
                uop.rd_idx      = rd;
            end
            `RV_OPC_BRANCH: begin
                uop.uop_class    = UOP_JUMP;
                uop.branch_cond  = decode_branch(funct3);
                uop.cmp_unsigned = funct3[1];
                uop.rs1_idx      = rs1;
                uop.rs2_idx      = rs2;
            end
            `RV_OPC_JAL: begin
                uop.uop_class   = UOP_JUMP;
                uop.branch_cond = BR_JAL;
                uop.src2_is_imm = 1'b1;
                uop.rd_idx      = rd;
            end
            `RV_OPC_JALR: begin
                uop.uop_class   = UOP_JUMP;
                uop.branch_cond = BR_JALR;
                uop.src2_is_imm = 1'b1;
                uop.rs1_idx     = rs1;
                uop.rd_idx      = rd;
            end
            default: begin
                // unknown opcode leaves class none
                uop.uop_class = UOP_NONE;
            end
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module tb_decode_stage \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_decode_stage 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1

//--- sources.f
+incdir+hdl
+incdir+bench
hdl/rv_decode_pkg.sv
hdl/imm_gen.sv
hdl/uop_decoder.sv
hdl/decode_pipe_reg.sv
hdl/decode_stage.sv
bench/tb_decode_stage.sv
